// File: logic/vproc_pkg.sv
package vproc_pkg;

    // Datapath widths and register counts
    localparam int xlen   = 32;
    localparam int lanes  = 4;
    localparam int vlen   = lanes * xlen;
    localparam int s_regs = 16;
    localparam int v_regs = 8;
    localparam int s_aw   = $clog2(s_regs);
    localparam int v_aw   = $clog2(v_regs);

    // Codes not listed here are illegal
    typedef enum logic [3:0] {
        op_add    = 4'h0,
        op_sub    = 4'h1,
        op_xor    = 4'h2,
        op_addi   = 4'h3,
        op_lui    = 4'h4,
        op_vadd   = 4'h8,
        op_vmul   = 4'h9,
        op_vsplat = 4'ha
    } opcode_e;

    typedef struct packed {
        opcode_e         op;
        logic [3:0]      rd;
        logic [3:0]      rs1;
        logic [3:0]      rs2;
        logic [15:0]     imm;
    } s_fmt_t;

    // Mask bit i enables lane i
    typedef struct packed {
        opcode_e         op;
        logic [2:0]      vd;
        logic [2:0]      vs1;
        logic [2:0]      vs2;
        logic [3:0]      rs;
        logic [3:0]      mask;
        logic [10:0]     unused;
    } v_fmt_t;

    typedef union packed {
        s_fmt_t s;
        v_fmt_t v;
    } instr_u;

    function automatic logic is_vector_op(opcode_e op);
        return op inside {op_vadd, op_vmul, op_vsplat};
    endfunction

endpackage

// File: logic/ctrl_if.sv
`timescale 1ns/1ps

// Control word that travels beside the vector datapath
interface ctrl_if;
    import vproc_pkg::*;

    logic             valid;
    opcode_e          op;
    // Vector ops only use the low bits
    logic [s_aw-1:0]  dest;
    logic [lanes-1:0] mask;

    modport src (
        output valid,
        output op,
        output dest,
        output mask
    );

    modport snk (
        input valid,
        input op,
        input dest,
        input mask
    );

endinterface

// File: logic/control_pipeline.sv
`timescale 1ns/1ps

module control_pipeline (
    input logic clk,
    input logic rst_n,
    ctrl_if.snk control_d,
    ctrl_if.src control_q
);
    import vproc_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            control_q.valid <= 1'b0;
            control_q.op    <= op_add;
            control_q.dest  <= '0;
            control_q.mask  <= '0;
        end else begin
            control_q.valid <= control_d.valid;
            control_q.op    <= control_d.op;
            control_q.dest  <= control_d.dest;
            control_q.mask  <= control_d.mask;
        end
    end

endmodule

// File: logic/reg_files.sv
`timescale 1ns/1ps

module reg_files (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [vproc_pkg::s_aw-1:0] s_raddr1,
    input  logic [vproc_pkg::s_aw-1:0] s_raddr2,
    input  logic [vproc_pkg::s_aw-1:0] s_raddr3,
    output logic [vproc_pkg::xlen-1:0] s_rdata1,
    output logic [vproc_pkg::xlen-1:0] s_rdata2,
    output logic [vproc_pkg::xlen-1:0] s_rdata3,
    input  logic                       s_we,
    input  logic [vproc_pkg::s_aw-1:0] s_waddr,
    input  logic [vproc_pkg::xlen-1:0] s_wdata,
    input  logic [vproc_pkg::v_aw-1:0] v_raddr1,
    input  logic [vproc_pkg::v_aw-1:0] v_raddr2,
    output logic [vproc_pkg::vlen-1:0] v_rdata1,
    output logic [vproc_pkg::vlen-1:0] v_rdata2,
    input  logic                       v_we,
    input  logic [vproc_pkg::v_aw-1:0] v_waddr,
    input  logic [vproc_pkg::lanes-1:0] v_wmask,
    input  logic [vproc_pkg::vlen-1:0] v_wdata
);
    import vproc_pkg::*;

    logic [xlen-1:0] s_mem [s_regs];
    logic [vlen-1:0] v_mem [v_regs];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < s_regs; i++) begin
                s_mem[i] <= '0;
            end
        end else if (s_we) begin
            s_mem[s_waddr] <= s_wdata;
        end
    end

    // Lanes with a clear mask bit keep their old contents
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < v_regs; i++) begin
                v_mem[i] <= '0;
            end
        end else if (v_we) begin
            for (int l = 0; l < lanes; l++) begin
                if (v_wmask[l]) begin
                    v_mem[v_waddr][l*xlen +: xlen] <= v_wdata[l*xlen +: xlen];
                end
            end
        end
    end

    assign s_rdata1 = s_mem[s_raddr1];
    assign s_rdata2 = s_mem[s_raddr2];
    assign s_rdata3 = s_mem[s_raddr3];
    assign v_rdata1 = v_mem[v_raddr1];
    assign v_rdata2 = v_mem[v_raddr2];

endmodule

// File: logic/decode.sv
`timescale 1ns/1ps

module decode (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       inst_valid,
    input  vproc_pkg::instr_u          inst,
    output logic                       inst_ready,
    output logic [vproc_pkg::s_aw-1:0] s_raddr1,
    output logic [vproc_pkg::s_aw-1:0] s_raddr2,
    output logic [vproc_pkg::s_aw-1:0] s_raddr3,
    input  logic [vproc_pkg::xlen-1:0] s_rdata1,
    input  logic [vproc_pkg::xlen-1:0] s_rdata2,
    input  logic [vproc_pkg::xlen-1:0] s_rdata3,
    output logic [vproc_pkg::v_aw-1:0] v_raddr1,
    output logic [vproc_pkg::v_aw-1:0] v_raddr2,
    input  logic [vproc_pkg::vlen-1:0] v_rdata1,
    input  logic [vproc_pkg::vlen-1:0] v_rdata2,
    output logic                       s_issue,
    output vproc_pkg::opcode_e         s_op,
    output logic [vproc_pkg::s_aw-1:0] s_dest,
    output logic [vproc_pkg::xlen-1:0] s_opa,
    output logic [vproc_pkg::xlen-1:0] s_opb,
    ctrl_if.src                        v_ctrl,
    output logic [vproc_pkg::vlen-1:0] v_opa,
    output logic [vproc_pkg::vlen-1:0] v_opb,
    output logic [vproc_pkg::xlen-1:0] v_scalar,
    input  logic [vproc_pkg::s_aw-1:0] s_done_addr,
    input  logic                       s_done,
    input  logic [vproc_pkg::v_aw-1:0] v_done_addr,
    input  logic                       v_done,
    output logic                       err
);
    import vproc_pkg::*;

    opcode_e           op;
    logic              legal;
    logic              hazard;
    logic              accept;
    logic              s_accept;
    logic              v_accept;
    logic [xlen-1:0]   imm_ext;
    logic [s_regs-1:0] s_busy, s_set, s_clr;
    logic [v_regs-1:0] v_busy, v_set, v_clr;

    // ******************************
    // Field decode and operand read
    // ******************************
    assign op       = inst.s.op;
    assign s_raddr1 = inst.s.rs1;
    assign s_raddr2 = inst.s.rs2;
    assign s_raddr3 = inst.v.rs;
    assign v_raddr1 = inst.v.vs1;
    assign v_raddr2 = inst.v.vs2;
    assign imm_ext  = {{(xlen-16){inst.s.imm[15]}}, inst.s.imm};

    // Only the registers an opcode really reads or writes can stall it
    always_comb begin
        legal  = 1'b1;
        hazard = 1'b0;
        case (op)
            op_add, op_sub, op_xor:
                hazard = s_busy[inst.s.rs1] | s_busy[inst.s.rs2] | s_busy[inst.s.rd];
            op_addi:    hazard = s_busy[inst.s.rs1] | s_busy[inst.s.rd];
            op_lui:     hazard = s_busy[inst.s.rd];
            op_vadd, op_vmul:
                hazard = v_busy[inst.v.vs1] | v_busy[inst.v.vs2] | v_busy[inst.v.vd];
            op_vsplat:  hazard = s_busy[inst.v.rs] | v_busy[inst.v.vd];
            default:    legal = 1'b0;
        endcase
    end

    assign inst_ready = !hazard;
    assign accept     = inst_valid && inst_ready;
    assign s_accept   = accept && legal && !is_vector_op(op);
    assign v_accept   = accept && legal && is_vector_op(op);

    // ******************************
    // Issue registers
    // ******************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_issue      <= 1'b0;
            v_ctrl.valid <= 1'b0;
            v_ctrl.op    <= op_add;
            v_ctrl.dest  <= '0;
            v_ctrl.mask  <= '0;
        end else begin
            s_issue      <= s_accept;
            v_ctrl.valid <= v_accept;
            if (v_accept) begin
                v_ctrl.op   <= op;
                v_ctrl.dest <= s_aw'(inst.v.vd);
                v_ctrl.mask <= inst.v.mask;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s_accept) begin
            s_op   <= op;
            s_dest <= inst.s.rd;
            s_opa  <= s_rdata1;
            s_opb  <= (op == op_addi || op == op_lui) ? imm_ext : s_rdata2;
        end
        if (v_accept) begin
            v_opa    <= v_rdata1;
            v_opb    <= v_rdata2;
            v_scalar <= s_rdata3;
        end
    end

    // ******************************
    // Scoreboard and error flag
    // ******************************
    always_comb begin
        s_set = '0;
        s_clr = '0;
        v_set = '0;
        v_clr = '0;
        if (s_accept) s_set[inst.s.rd] = 1'b1;
        if (v_accept) v_set[inst.v.vd] = 1'b1;
        if (s_done) s_clr[s_done_addr] = 1'b1;
        if (v_done) v_clr[v_done_addr] = 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_busy <= '0;
            v_busy <= '0;
            err    <= 1'b0;
        end else begin
            s_busy <= (s_busy & ~s_clr) | s_set;
            v_busy <= (v_busy & ~v_clr) | v_set;
            if (accept && !legal) err <= 1'b1;
        end
    end

endmodule

// File: logic/scalar_execute.sv
`timescale 1ns/1ps

module scalar_execute (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       issue,
    input  vproc_pkg::opcode_e         op,
    input  logic [vproc_pkg::s_aw-1:0] dest,
    input  logic [vproc_pkg::xlen-1:0] opa,
    input  logic [vproc_pkg::xlen-1:0] opb,
    output logic                       wb_valid,
    output logic [vproc_pkg::s_aw-1:0] wb_addr,
    output logic [vproc_pkg::xlen-1:0] wb_data
);
    import vproc_pkg::*;

    logic [xlen-1:0] result;

    // opb already carries the sign-extended immediate for addi and lui
    always_comb begin
        case (op)
            op_add, op_addi: result = opa + opb;
            op_sub:          result = opa - opb;
            op_xor:          result = opa ^ opb;
            op_lui:          result = {opb[15:0], 16'h0000};
            default:         result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            wb_addr <= dest;
            wb_data <= result;
        end
    end

endmodule

// File: logic/vector_execute.sv
`timescale 1ns/1ps

module vector_execute #(
    parameter int VECTOR_STAGES = 3
) (
    input  logic                       clk,
    input  logic                       rst_n,
    ctrl_if.snk                        ctrl_in,
    input  logic [vproc_pkg::vlen-1:0] vopa,
    input  logic [vproc_pkg::vlen-1:0] vopb,
    input  logic [vproc_pkg::xlen-1:0] scalar,
    output logic [vproc_pkg::vlen-1:0] vdata_out
);
    import vproc_pkg::*;

    logic [vlen-1:0] lane_res;
    logic [vlen-1:0] stage_q [VECTOR_STAGES];

    if (VECTOR_STAGES < 1 || VECTOR_STAGES > 4) begin : g_bad_depth
        $error("VECTOR_STAGES must lie between 1 and 4");
    end

    // Lane l occupies bits l*xlen and up
    always_comb begin
        for (int l = 0; l < lanes; l++) begin
            case (ctrl_in.op)
                op_vadd:   lane_res[l*xlen +: xlen] = vopa[l*xlen +: xlen] + vopb[l*xlen +: xlen];
                op_vmul:   lane_res[l*xlen +: xlen] = vopa[l*xlen +: xlen] * vopb[l*xlen +: xlen];
                op_vsplat: lane_res[l*xlen +: xlen] = scalar;
                default:   lane_res[l*xlen +: xlen] = '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_q[0] <= '0;
        end else if (ctrl_in.valid) begin
            stage_q[0] <= lane_res;
        end
    end

    // Later stages only delay the result to match the control chain
    for (genvar s = 1; s < VECTOR_STAGES; s++) begin : g_carry
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                stage_q[s] <= '0;
            end else begin
                stage_q[s] <= stage_q[s-1];
            end
        end
    end

    assign vdata_out = stage_q[VECTOR_STAGES-1];

endmodule

// File: logic/vproc.sv
`timescale 1ns/1ps

module vproc #(
    parameter int VECTOR_STAGES = 3
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        inst_valid,
    input  logic [31:0]                 inst,
    output logic                        inst_ready,
    output logic                        s_wb_valid,
    output logic [vproc_pkg::s_aw-1:0]  s_wb_addr,
    output logic [vproc_pkg::xlen-1:0]  s_wb_data,
    output logic                        v_wb_valid,
    output logic [vproc_pkg::v_aw-1:0]  v_wb_addr,
    output logic [vproc_pkg::lanes-1:0] v_wb_mask,
    output logic [vproc_pkg::vlen-1:0]  v_wb_data,
    output logic                        err
);
    import vproc_pkg::*;

    logic [s_aw-1:0]  s_raddr1, s_raddr2, s_raddr3;
    logic [xlen-1:0]  s_rdata1, s_rdata2, s_rdata3;
    logic [v_aw-1:0]  v_raddr1, v_raddr2;
    logic [vlen-1:0]  v_rdata1, v_rdata2;
    logic             s_issue;
    opcode_e          s_op;
    logic [s_aw-1:0]  s_dest;
    logic [xlen-1:0]  s_opa, s_opb;
    logic [vlen-1:0]  v_opa, v_opb;
    logic [xlen-1:0]  v_scalar;
    logic [vlen-1:0]  vdata_out;
    logic             last_valid;
    logic [s_aw-1:0]  last_dest;
    logic [lanes-1:0] last_mask;

    // Entry 0 is driven by decode, entry VECTOR_STAGES is the last stage
    ctrl_if v_ctrl [VECTOR_STAGES+1] ();

    decode u_decode (
        .clk, .rst_n, .inst_valid, .inst, .inst_ready,
        .s_raddr1, .s_raddr2, .s_raddr3, .s_rdata1, .s_rdata2, .s_rdata3,
        .v_raddr1, .v_raddr2, .v_rdata1, .v_rdata2,
        .s_issue, .s_op, .s_dest, .s_opa, .s_opb,
        .v_ctrl(v_ctrl[0]), .v_opa, .v_opb, .v_scalar,
        .s_done_addr(s_wb_addr), .s_done(s_wb_valid),
        .v_done_addr(v_wb_addr), .v_done(v_wb_valid),
        .err
    );

    reg_files u_reg_files (
        .clk, .rst_n,
        .s_raddr1, .s_raddr2, .s_raddr3, .s_rdata1, .s_rdata2, .s_rdata3,
        .s_we(s_wb_valid), .s_waddr(s_wb_addr), .s_wdata(s_wb_data),
        .v_raddr1, .v_raddr2, .v_rdata1, .v_rdata2,
        .v_we(v_wb_valid), .v_waddr(v_wb_addr), .v_wmask(v_wb_mask), .v_wdata(v_wb_data)
    );

    scalar_execute u_scalar_execute (
        .clk, .rst_n, .issue(s_issue), .op(s_op), .dest(s_dest), .opa(s_opa), .opb(s_opb),
        .wb_valid(s_wb_valid), .wb_addr(s_wb_addr), .wb_data(s_wb_data)
    );

    vector_execute #(.VECTOR_STAGES(VECTOR_STAGES)) u_vector_execute (
        .clk, .rst_n, .ctrl_in(v_ctrl[0]),
        .vopa(v_opa), .vopb(v_opb), .scalar(v_scalar), .vdata_out
    );

    // ******************************
    // Vector control chain
    // ******************************
    for (genvar g = 0; g < VECTOR_STAGES; g++) begin : g_ctrl
        control_pipeline u_stage (
            .clk, .rst_n, .control_d(v_ctrl[g]), .control_q(v_ctrl[g+1])
        );
    end

    assign last_valid = v_ctrl[VECTOR_STAGES].valid;
    assign last_dest  = v_ctrl[VECTOR_STAGES].dest;
    assign last_mask  = v_ctrl[VECTOR_STAGES].mask;

    // Vector writeback register, the counterpart of the scalar result register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v_wb_valid <= 1'b0;
        end else begin
            v_wb_valid <= last_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (last_valid) begin
            v_wb_addr <= last_dest[v_aw-1:0];
            v_wb_mask <= last_mask;
            v_wb_data <= vdata_out;
        end
    end

endmodule

// File: testbench/vproc_asserts.sv
`timescale 1ns/1ps

module vproc_asserts (
    input logic        clk,
    input logic        rst_n,
    input logic        inst_valid,
    input logic [31:0] inst,
    input logic        inst_ready,
    input logic        s_wb_valid,
    input logic        v_wb_valid,
    input logic        err
);
    import vproc_pkg::*;

    int unsigned fail_count = 0;
    logic        s_accept;

    // Scalar opcodes are the legal ones outside the vector group
    assign s_accept = inst_valid && inst_ready &&
                      (inst[31:28] inside {op_add, op_sub, op_xor, op_addi, op_lui});

    a_scalar_wb: assert property (@(posedge clk) disable iff (!rst_n)
        s_accept |-> ##2 s_wb_valid)
    else begin
        fail_count++;
        $error("s_wb_valid did not follow a scalar acceptance two edges later");
    end

    a_scalar_wb_cause: assert property (@(posedge clk) disable iff (!rst_n)
        s_wb_valid |-> $past(s_accept, 2))
    else begin
        fail_count++;
        $error("s_wb_valid without a scalar acceptance two edges earlier");
    end

    // The error flag is sticky until reset
    a_err_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        err |=> err)
    else begin
        fail_count++;
        $error("err fell while rst_n was high");
    end

    a_quiet_reset: assert property (@(posedge clk)
        !rst_n |-> !s_wb_valid && !v_wb_valid)
    else begin
        fail_count++;
        $error("writeback valid high during reset");
    end

endmodule

bind vproc vproc_asserts u_vproc_asserts (.*);

// File: testbench/vproc_tb.sv
`timescale 1ns/1ps

module vproc_tb;
    import vproc_pkg::*;

    localparam int VECTOR_STAGES = 3;
    // All six tests together take a few hundred cycles
    localparam int max_cycles = 4000;

    logic             clk;
    logic             rst_n;
    logic             inst_valid;
    logic [31:0]      inst;
    logic             inst_ready;
    logic             s_wb_valid;
    logic [s_aw-1:0]  s_wb_addr;
    logic [xlen-1:0]  s_wb_data;
    logic             v_wb_valid;
    logic [v_aw-1:0]  v_wb_addr;
    logic [lanes-1:0] v_wb_mask;
    logic [vlen-1:0]  v_wb_data;
    logic             err;

    // Reference register files and the writebacks the DUT still owes
    logic [xlen-1:0]  m_s [s_regs];
    logic [vlen-1:0]  m_v [v_regs];
    bit               s_pend [s_regs];
    bit               v_pend [v_regs];
    logic [xlen-1:0]  s_exp [s_regs];
    logic [vlen-1:0]  v_exp [v_regs];
    logic [lanes-1:0] v_exp_mask [v_regs];
    int               s_due [s_regs];
    int               v_due [v_regs];
    int               cycle = 0;
    int               v_peak;
    logic [31:0]      rng;
    string            test_name;

    vproc #(.VECTOR_STAGES(VECTOR_STAGES)) vproc_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= max_cycles) begin
            $display("Timeout after %0d cycles in %s, the DUT stopped making progress",
                     cycle, test_name);
            abort_run();
        end
    end

    // ******************************
    // Helpers
    // ******************************
    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check(input string what, input logic [vlen-1:0] expected,
                         input logic [vlen-1:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: %s expected 'h%0h actual 'h%0h",
                     test_name, what, expected, actual);
            abort_run();
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] s_word(input logic [3:0] op, input int rd, input int rs1,
                                           input int rs2, input logic [15:0] imm);
        return {op, 4'(rd), 4'(rs1), 4'(rs2), imm};
    endfunction

    function automatic logic [31:0] v_word(input logic [3:0] op, input int vd, input int vs1,
                                           input int vs2, input int rs, input logic [3:0] mask);
        return {op, 3'(vd), 3'(vs1), 3'(vs2), 4'(rs), mask, 11'd0};
    endfunction

    function automatic int pending_count();
        int n;
        n = 0;
        foreach (s_pend[i]) n += s_pend[i];
        foreach (v_pend[i]) n += v_pend[i];
        return n;
    endfunction

    // Applies an accepted word to the model and records the writeback it owes
    task automatic model_issue(input logic [31:0] w);
        logic [3:0]      op;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] r;
        logic [vlen-1:0] vr;
        int              rd;
        int              vd;
        op = w[31:28];
        rd = w[27:24];
        vd = w[27:25];
        if (!(op inside {op_add, op_sub, op_xor, op_addi, op_lui,
                         op_vadd, op_vmul, op_vsplat})) begin
            return;
        end
        if (!is_vector_op(opcode_e'(op))) begin
            a = m_s[w[23:20]];
            b = m_s[w[19:16]];
            case (op)
                op_add:  r = a + b;
                op_sub:  r = a - b;
                op_xor:  r = a ^ b;
                op_addi: r = a + {{16{w[15]}}, w[15:0]};
                default: r = {w[15:0], 16'h0000};
            endcase
            m_s[rd] = r;
            s_exp[rd] = r;
            s_pend[rd] = 1'b1;
            s_due[rd] = cycle + 1;
        end else begin
            for (int l = 0; l < lanes; l++) begin
                a = m_v[w[24:22]][l*xlen +: xlen];
                b = m_v[w[21:19]][l*xlen +: xlen];
                case (op)
                    op_vadd: r = a + b;
                    op_vmul: r = a * b;
                    default: r = m_s[w[18:15]];
                endcase
                vr[l*xlen +: xlen] = r;
                if (w[11+l]) m_v[vd][l*xlen +: xlen] = r;
            end
            v_exp[vd] = vr;
            v_exp_mask[vd] = w[14:11];
            v_pend[vd] = 1'b1;
            v_due[vd] = cycle + 1 + VECTOR_STAGES;
        end
    endtask

    // Starts and ends 1 ns after a rising edge and holds the word until it is taken
    task automatic send(input logic [31:0] w);
        bit taken;
        int in_flight;
        taken = 1'b0;
        inst = w;
        inst_valid = 1'b1;
        while (!taken) begin
            @(negedge clk);
            taken = inst_ready;
            @(posedge clk);
        end
        #1;
        inst_valid = 1'b0;
        model_issue(w);
        in_flight = 0;
        foreach (v_pend[i]) in_flight += v_pend[i];
        if (in_flight > v_peak) v_peak = in_flight;
    endtask

    task automatic drain();
        while (pending_count() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && s_wb_valid) begin
            if (!s_pend[s_wb_addr]) begin
                $display("Scalar writeback to x%0d that no instruction owed", s_wb_addr);
                abort_run();
            end else begin
                check("scalar data", s_exp[s_wb_addr], s_wb_data);
                check("scalar writeback cycle", s_due[s_wb_addr], cycle);
                s_pend[s_wb_addr] = 1'b0;
            end
        end
        if (rst_n && v_wb_valid) begin
            if (!v_pend[v_wb_addr]) begin
                $display("Vector writeback to v%0d that no instruction owed", v_wb_addr);
                abort_run();
            end else begin
                check("vector data", v_exp[v_wb_addr], v_wb_data);
                check("vector mask", v_exp_mask[v_wb_addr], v_wb_mask);
                check("vector writeback cycle", v_due[v_wb_addr], cycle);
                v_pend[v_wb_addr] = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (vproc_i.u_vproc_asserts.fail_count != 0) begin
            $display("An assertion on the DUT failed during %s", test_name);
            abort_run();
        end
    end

    // ******************************
    // Directed tests
    // ******************************
    task automatic scalar_timing();
        test_name = "scalar_timing";
        send(s_word(op_lui, 1, 0, 0, 16'h1234));
        send(s_word(op_addi, 2, 0, 0, 16'h5678));
        send(s_word(op_addi, 3, 0, 0, 16'hfffd));
        drain();
        send(s_word(op_add, 4, 1, 2, 16'h0));
        send(s_word(op_sub, 5, 2, 1, 16'h0));
        send(s_word(op_xor, 6, 1, 3, 16'h0));
        drain();
        check("model constant in x4", 32'h1234_5678, m_s[4]);
    endtask

    task automatic dependency_chain();
        test_name = "dependency_chain";
        send(s_word(op_addi, 7, 0, 0, 16'd1));
        send(s_word(op_addi, 8, 7, 0, 16'd5));
        inst = s_word(op_add, 9, 8, 8, 16'h0);
        @(negedge clk);
        check("inst_ready with x8 busy", 1'b0, inst_ready);
        @(posedge clk);
        #1;
        send(s_word(op_add, 9, 8, 8, 16'h0));
        send(s_word(op_sub, 10, 9, 7, 16'h0));
        send(s_word(op_xor, 11, 10, 9, 16'h0));
        drain();
    endtask

    task automatic vector_ops();
        test_name = "vector_ops";
        send(s_word(op_addi, 12, 0, 0, 16'd7));
        send(s_word(op_addi, 13, 0, 0, 16'hfffe));
        send(v_word(op_vsplat, 1, 0, 0, 12, 4'hf));
        send(v_word(op_vsplat, 2, 0, 0, 13, 4'hf));
        send(v_word(op_vadd, 3, 1, 2, 0, 4'hf));
        send(v_word(op_vmul, 4, 1, 2, 0, 4'hf));
        send(v_word(op_vmul, 5, 4, 3, 0, 4'hf));
        drain();
    endtask

    task automatic lane_masks();
        test_name = "lane_masks";
        send(s_word(op_lui, 14, 0, 0, 16'h0001));
        send(v_word(op_vsplat, 6, 0, 0, 14, 4'hf));
        send(v_word(op_vadd, 6, 1, 2, 0, 4'b0101));
        send(v_word(op_vmul, 6, 1, 1, 0, 4'b1000));
        send(v_word(op_vadd, 7, 6, 6, 0, 4'hf));
        drain();
    endtask

    task automatic overlap();
        opcode_e s_ops [5];
        s_ops = '{op_add, op_sub, op_xor, op_addi, op_lui};
        test_name = "overlap";
        for (int r = 1; r < 8; r++) begin
            rng = xorshift(rng);
            send(s_word(op_lui, r, 0, 0, rng[31:16]));
            send(s_word(op_addi, r, r, 0, rng[15:0]));
        end
        for (int v = 0; v < 4; v++) begin
            rng = xorshift(rng);
            send(v_word(op_vsplat, v, 0, 0, v + 1, 4'hf));
            send(v_word(op_vsplat, v, 0, 0, v + 4, rng[3:0]));
        end
        drain();
        v_peak = 0;
        // Sources are never written here, so only the pipelines limit the rate
        for (int i = 0; i < 16; i++) begin
            rng = xorshift(rng);
            send(s_word(s_ops[rng[2:0] % 5], 8 + (i % 8), 1 + rng[5:3] % 7,
                        1 + rng[8:6] % 7, rng[31:16]));
            send(v_word(rng[9] ? op_vmul : op_vadd, 4 + (i % 4), rng[11:10],
                        rng[13:12], 0, rng[17:14]));
        end
        drain();
        check("several vector results in flight", 1'b1, v_peak >= 2);
    endtask

    task automatic illegal_op();
        test_name = "illegal_op";
        check("err before illegal op", 1'b0, err);
        send({4'hf, 4'd3, 24'h0});
        check("err after illegal op", 1'b1, err);
        repeat (8) @(posedge clk);
        #1;
        send(s_word(op_addi, 3, 0, 0, 16'd9));
        send(s_word(op_add, 15, 3, 3, 16'h0));
        drain();
        check("err still set", 1'b1, err);
    endtask

    initial begin
        rng = 32'hb862_4533;
        rst_n = 1'b0;
        inst_valid = 1'b0;
        inst = '0;
        v_peak = 0;
        test_name = "reset";
        foreach (m_s[i]) m_s[i] = '0;
        foreach (m_v[i]) m_v[i] = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        scalar_timing();
        dependency_chain();
        vector_ops();
        lane_masks();
        overlap();
        illegal_op();
        drain();
        if (vproc_i.u_vproc_asserts.fail_count == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("%0d assertion failures were reported",
                     vproc_i.u_vproc_asserts.fail_count);
            abort_run();
        end
    end

endmodule

// File: vproc.f
logic/vproc_pkg.sv
logic/ctrl_if.sv
logic/control_pipeline.sv
logic/reg_files.sv
logic/decode.sv
logic/scalar_execute.sv
logic/vector_execute.sv
logic/vproc.sv
testbench/vproc_asserts.sv
testbench/vproc_tb.sv
